//--- pj_pkg.sv
package pj_pkg;

  localparam int WIDTH_OP  = 4;
  localparam int NUM_FLAGS = 4;

  // flag bit positions
  localparam int FLAG_C = 3;
  localparam int FLAG_N = 2;
  localparam int FLAG_Z = 1;
  localparam int FLAG_V = 0;

  // codes 11 to 15 are undefined and land in the logic unit
  typedef enum logic [WIDTH_OP-1:0] {
    OP_AND  = 4'd0,
    OP_XOR  = 4'd1,
    OP_OR   = 4'd2,
    OP_NEG  = 4'd3,
    OP_LSLS = 4'd4,
    OP_LSRS = 4'd5,
    OP_ASRS = 4'd6,
    OP_RORS = 4'd7,
    OP_ADDS = 4'd8,
    OP_SUBS = 4'd9,
    OP_MULS = 4'd10
  } op_e;

  typedef enum logic [1:0] {
    UNIT_LOGIC = 2'd0,
    UNIT_ARITH = 2'd1,
    UNIT_MUL   = 2'd2
  } unit_e;

  function automatic unit_e unit_of(input op_e op);
    unit_e unit;
    case (op)
      OP_ADDS,
      OP_SUBS: unit = UNIT_ARITH;
      OP_MULS: unit = UNIT_MUL;
      default: unit = UNIT_LOGIC;
    endcase
    return unit;
  endfunction

  // N and Z from the result, C and V left clear
  function automatic logic [NUM_FLAGS-1:0] nz_flags(
    input logic top_bit,
    input logic is_zero
  );
    logic [NUM_FLAGS-1:0] flags;
    flags         = '0;
    flags[FLAG_N] = top_bit;
    flags[FLAG_Z] = is_zero;
    return flags;
  endfunction

endpackage

//--- fu_result_if.sv
`timescale 1ns/1ps

interface fu_result_if
  import pj_pkg::*;
#(
  parameter int WORD_SIZE_P  = 32,
  parameter int ROB_ENTRY    = 16,
  parameter int NUM_PHYS_REG = 64
);

  localparam int ROB_W = $clog2(ROB_ENTRY);
  localparam int REG_W = $clog2(NUM_PHYS_REG);

  logic                   valid;
  logic [ROB_W-1:0]       rob_dest;
  logic [REG_W-1:0]       reg_dest;
  logic [WORD_SIZE_P-1:0] result;
  logic [NUM_FLAGS-1:0]   flags;

  modport unit (output valid, rob_dest, reg_dest, result, flags);
  modport wb   (input  valid, rob_dest, reg_dest, result, flags);

endinterface

//--- exec_dispatch.sv
`timescale 1ns/1ps

module exec_dispatch
  import pj_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic issue_v_i,
  input  op_e  opcode_i,
  output logic issue_stall_o,
  output logic logic_v_o,
  output logic arith_v_o,
  output logic mul_v_o
);

  unit_e unit;
  logic  accept;
  logic  mul_last;

  assign unit = unit_of(opcode_i);

  // a non-mul result issued now would meet the pending product at writeback
  assign issue_stall_o = mul_last && (unit != UNIT_MUL);
  assign accept        = issue_v_i && !issue_stall_o;

  assign logic_v_o = accept && (unit == UNIT_LOGIC);
  assign arith_v_o = accept && (unit == UNIT_ARITH);
  assign mul_v_o   = accept && (unit == UNIT_MUL);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      mul_last <= 1'b0;
    end
    else
    begin
      mul_last <= mul_v_o;
    end
  end

endmodule

//--- fu_logic.sv
`timescale 1ns/1ps

module fu_logic
  import pj_pkg::*;
#(
  parameter int WORD_SIZE_P  = 32,
  parameter int ROB_ENTRY    = 16,
  parameter int NUM_PHYS_REG = 64
)
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            exe_v_i,
  input  op_e                             opcode_i,
  input  logic [WORD_SIZE_P-1:0]          operand1_i,
  input  logic [WORD_SIZE_P-1:0]          operand2_i,
  input  logic [$clog2(ROB_ENTRY)-1:0]    rob_dest_i,
  input  logic [$clog2(NUM_PHYS_REG)-1:0] reg_dest_i,
  fu_result_if.unit                       res_o
);

  localparam int SHAMT_W = $clog2(WORD_SIZE_P);

  logic [WORD_SIZE_P-1:0] and_res;
  logic [WORD_SIZE_P-1:0] xor_res;
  logic [WORD_SIZE_P-1:0] or_res;
  logic [WORD_SIZE_P-1:0] neg_res;
  logic [WORD_SIZE_P-1:0] lsls_res;
  logic [WORD_SIZE_P-1:0] lsrs_res;
  logic [WORD_SIZE_P-1:0] asrs_res;
  logic [WORD_SIZE_P-1:0] rors_res;
  logic [WORD_SIZE_P-1:0] lsl_last;
  logic [WORD_SIZE_P-1:0] lsr_last;
  logic [WORD_SIZE_P-1:0] asr_last;
  logic [SHAMT_W-1:0]     rot_amt;
  logic                   amt_zero;
  logic                   carry;
  logic [WORD_SIZE_P-1:0] result;
  logic [NUM_FLAGS-1:0]   flags;

  assign and_res = operand1_i & operand2_i;
  assign xor_res = operand1_i ^ operand2_i;
  assign or_res  = operand1_i | operand2_i;
  assign neg_res = ~operand2_i;

  // shift amount is the whole of operand2
  assign lsls_res = operand1_i << operand2_i;
  assign lsrs_res = operand1_i >> operand2_i;
  assign asrs_res = $signed(operand1_i) >>> operand2_i;

  // one step short, so the last bit out sits at the edge
  assign lsl_last = operand1_i << (operand2_i - 1'b1);
  assign lsr_last = operand1_i >> (operand2_i - 1'b1);
  assign asr_last = $signed(operand1_i) >>> (operand2_i - 1'b1);
  assign amt_zero = (operand2_i == '0);

  assign rot_amt  = operand2_i[SHAMT_W-1:0];
  assign rors_res = (operand1_i >> rot_amt) | (operand1_i << (WORD_SIZE_P - rot_amt));

  always_comb
  begin
    carry = 1'b0;
    case (opcode_i)
      OP_AND:  result = and_res;
      OP_XOR:  result = xor_res;
      OP_OR:   result = or_res;
      OP_NEG:  result = neg_res;
      OP_LSLS:
      begin
        result = lsls_res;
        carry  = lsl_last[WORD_SIZE_P-1];
      end
      OP_LSRS:
      begin
        result = lsrs_res;
        carry  = lsr_last[0];
      end
      OP_ASRS:
      begin
        result = asrs_res;
        carry  = asr_last[0];
      end
      OP_RORS:
      begin
        result = rors_res;
        carry  = rors_res[WORD_SIZE_P-1];
      end
      default: result = '0;
    endcase
    flags         = nz_flags(result[WORD_SIZE_P-1], result == '0);
    flags[FLAG_C] = carry && !amt_zero;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      res_o.valid <= 1'b0;
    end
    else
    begin
      res_o.valid <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    res_o.rob_dest <= rob_dest_i;
    res_o.reg_dest <= reg_dest_i;
    res_o.result   <= result;
    res_o.flags    <= flags;
  end

endmodule

//--- fu_arith.sv
`timescale 1ns/1ps

module fu_arith
  import pj_pkg::*;
#(
  parameter int WORD_SIZE_P  = 32,
  parameter int ROB_ENTRY    = 16,
  parameter int NUM_PHYS_REG = 64
)
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            exe_v_i,
  input  op_e                             opcode_i,
  input  logic [WORD_SIZE_P-1:0]          operand1_i,
  input  logic [WORD_SIZE_P-1:0]          operand2_i,
  input  logic [$clog2(ROB_ENTRY)-1:0]    rob_dest_i,
  input  logic [$clog2(NUM_PHYS_REG)-1:0] reg_dest_i,
  fu_result_if.unit                       res_o
);

  localparam int MSB = WORD_SIZE_P - 1;

  logic                 is_sub;
  logic [WORD_SIZE_P:0] sum;
  logic [NUM_FLAGS-1:0] flags;

  assign is_sub = (opcode_i == OP_SUBS);

  // extra top bit holds the carry, inverted borrow on subtract
  assign sum = is_sub ? {1'b0, operand1_i} - {1'b0, operand2_i}
                      : {1'b0, operand1_i} + {1'b0, operand2_i};

  always_comb
  begin
    flags         = nz_flags(sum[MSB], sum[MSB:0] == '0);
    flags[FLAG_C] = sum[WORD_SIZE_P] ^ is_sub;
    // operand signs agree for add, differ for sub, and result sign flips
    flags[FLAG_V] = ((operand1_i[MSB] ^ operand2_i[MSB]) == is_sub)
                 && (sum[MSB] != operand1_i[MSB]);
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      res_o.valid <= 1'b0;
    end
    else
    begin
      res_o.valid <= exe_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    res_o.rob_dest <= rob_dest_i;
    res_o.reg_dest <= reg_dest_i;
    res_o.result   <= sum[MSB:0];
    res_o.flags    <= flags;
  end

endmodule

//--- fu_mul.sv
`timescale 1ns/1ps

module fu_mul
  import pj_pkg::*;
#(
  parameter int WORD_SIZE_P  = 32,
  parameter int ROB_ENTRY    = 16,
  parameter int NUM_PHYS_REG = 64
)
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            exe_v_i,
  input  logic [WORD_SIZE_P-1:0]          operand1_i,
  input  logic [WORD_SIZE_P-1:0]          operand2_i,
  input  logic [$clog2(ROB_ENTRY)-1:0]    rob_dest_i,
  input  logic [$clog2(NUM_PHYS_REG)-1:0] reg_dest_i,
  fu_result_if.unit                       res_o
);

  logic                            s1_valid;
  logic [2*WORD_SIZE_P-1:0]        s1_product;
  logic [$clog2(ROB_ENTRY)-1:0]    s1_rob_dest;
  logic [$clog2(NUM_PHYS_REG)-1:0] s1_reg_dest;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      s1_valid    <= 1'b0;
      res_o.valid <= 1'b0;
    end
    else
    begin
      s1_valid    <= exe_v_i;
      res_o.valid <= s1_valid;
    end
  end

  // stage one multiplies, stage two keeps the low word and sets N and Z
  always_ff @(posedge clk_i)
  begin
    s1_product     <= operand1_i * operand2_i;
    s1_rob_dest    <= rob_dest_i;
    s1_reg_dest    <= reg_dest_i;
    res_o.rob_dest <= s1_rob_dest;
    res_o.reg_dest <= s1_reg_dest;
    res_o.result   <= s1_product[WORD_SIZE_P-1:0];
    res_o.flags    <= nz_flags(s1_product[WORD_SIZE_P-1], s1_product[WORD_SIZE_P-1:0] == '0);
  end

endmodule

//--- cdb_writeback.sv
`timescale 1ns/1ps

module cdb_writeback
  import pj_pkg::*;
#(
  parameter int WORD_SIZE_P  = 32,
  parameter int ROB_ENTRY    = 16,
  parameter int NUM_PHYS_REG = 64
)
(
  input  logic                             clk_i,
  input  logic                             reset_i,
  fu_result_if.wb                          logic_i,
  fu_result_if.wb                          arith_i,
  fu_result_if.wb                          mul_i,
  output logic                             wb_v_o,
  output logic [$clog2(ROB_ENTRY)-1:0]     wb_rob_dest_o,
  output logic [$clog2(NUM_PHYS_REG)-1:0]  wb_reg_dest_o,
  output logic [WORD_SIZE_P-1:0]           wb_result_o,
  output logic [NUM_FLAGS-1:0]             wb_flags_o
);

  localparam int ROB_W = $clog2(ROB_ENTRY);
  localparam int REG_W = $clog2(NUM_PHYS_REG);

  logic                   any_v;
  logic [ROB_W-1:0]       rob_dest;
  logic [REG_W-1:0]       reg_dest;
  logic [WORD_SIZE_P-1:0] result;
  logic [NUM_FLAGS-1:0]   flags;

  // at most one unit is valid per cycle, so gated fields can be or-ed
  assign any_v    = logic_i.valid | arith_i.valid | mul_i.valid;
  assign rob_dest = ({ROB_W{logic_i.valid}} & logic_i.rob_dest)
                  | ({ROB_W{arith_i.valid}} & arith_i.rob_dest)
                  | ({ROB_W{mul_i.valid}}   & mul_i.rob_dest);
  assign reg_dest = ({REG_W{logic_i.valid}} & logic_i.reg_dest)
                  | ({REG_W{arith_i.valid}} & arith_i.reg_dest)
                  | ({REG_W{mul_i.valid}}   & mul_i.reg_dest);
  assign result   = ({WORD_SIZE_P{logic_i.valid}} & logic_i.result)
                  | ({WORD_SIZE_P{arith_i.valid}} & arith_i.result)
                  | ({WORD_SIZE_P{mul_i.valid}}   & mul_i.result);
  assign flags    = ({NUM_FLAGS{logic_i.valid}} & logic_i.flags)
                  | ({NUM_FLAGS{arith_i.valid}} & arith_i.flags)
                  | ({NUM_FLAGS{mul_i.valid}}   & mul_i.flags);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wb_v_o <= 1'b0;
    end
    else
    begin
      wb_v_o <= any_v;
    end
  end

  always_ff @(posedge clk_i)
  begin
    wb_rob_dest_o <= rob_dest;
    wb_reg_dest_o <= reg_dest;
    wb_result_o   <= result;
    wb_flags_o    <= flags;
  end

endmodule

//--- exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster
  import pj_pkg::*;
#(
  parameter int WORD_SIZE_P  = 32,
  parameter int ROB_ENTRY    = 16,
  parameter int NUM_PHYS_REG = 64
)
(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            issue_v_i,
  input  op_e                             opcode_i,
  input  logic [WORD_SIZE_P-1:0]          operand1_i,
  input  logic [WORD_SIZE_P-1:0]          operand2_i,
  input  logic [$clog2(ROB_ENTRY)-1:0]    rob_dest_i,
  input  logic [$clog2(NUM_PHYS_REG)-1:0] reg_dest_i,
  output logic                            issue_stall_o,
  output logic                            wb_v_o,
  output logic [$clog2(ROB_ENTRY)-1:0]    wb_rob_dest_o,
  output logic [$clog2(NUM_PHYS_REG)-1:0] wb_reg_dest_o,
  output logic [WORD_SIZE_P-1:0]          wb_result_o,
  output logic [NUM_FLAGS-1:0]            wb_flags_o
);

  logic logic_v;
  logic arith_v;
  logic mul_v;

  fu_result_if #(.WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY(ROB_ENTRY),
                 .NUM_PHYS_REG(NUM_PHYS_REG)) logic_res ();
  fu_result_if #(.WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY(ROB_ENTRY),
                 .NUM_PHYS_REG(NUM_PHYS_REG)) arith_res ();
  fu_result_if #(.WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY(ROB_ENTRY),
                 .NUM_PHYS_REG(NUM_PHYS_REG)) mul_res ();

  exec_dispatch u_dispatch (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_v_i     (issue_v_i),
    .opcode_i      (opcode_i),
    .issue_stall_o (issue_stall_o),
    .logic_v_o     (logic_v),
    .arith_v_o     (arith_v),
    .mul_v_o       (mul_v)
  );

  // operands and tags go to every unit, the strobe picks the one that acts
  fu_logic #(.WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY(ROB_ENTRY),
             .NUM_PHYS_REG(NUM_PHYS_REG)) u_logic (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .exe_v_i    (logic_v),
    .opcode_i   (opcode_i),
    .operand1_i (operand1_i),
    .operand2_i (operand2_i),
    .rob_dest_i (rob_dest_i),
    .reg_dest_i (reg_dest_i),
    .res_o      (logic_res.unit)
  );

  fu_arith #(.WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY(ROB_ENTRY),
             .NUM_PHYS_REG(NUM_PHYS_REG)) u_arith (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .exe_v_i    (arith_v),
    .opcode_i   (opcode_i),
    .operand1_i (operand1_i),
    .operand2_i (operand2_i),
    .rob_dest_i (rob_dest_i),
    .reg_dest_i (reg_dest_i),
    .res_o      (arith_res.unit)
  );

  fu_mul #(.WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY(ROB_ENTRY),
           .NUM_PHYS_REG(NUM_PHYS_REG)) u_mul (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .exe_v_i    (mul_v),
    .operand1_i (operand1_i),
    .operand2_i (operand2_i),
    .rob_dest_i (rob_dest_i),
    .reg_dest_i (reg_dest_i),
    .res_o      (mul_res.unit)
  );

  cdb_writeback #(.WORD_SIZE_P(WORD_SIZE_P), .ROB_ENTRY(ROB_ENTRY),
                  .NUM_PHYS_REG(NUM_PHYS_REG)) u_writeback (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .logic_i       (logic_res.wb),
    .arith_i       (arith_res.wb),
    .mul_i         (mul_res.wb),
    .wb_v_o        (wb_v_o),
    .wb_rob_dest_o (wb_rob_dest_o),
    .wb_reg_dest_o (wb_reg_dest_o),
    .wb_result_o   (wb_result_o),
    .wb_flags_o    (wb_flags_o)
  );

endmodule

//--- tb_exec_cluster.sv
`timescale 1ns/1ps

module tb_exec_cluster
  import pj_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_DIRECTED = 150;
  localparam int NUM_RANDOM   = 300;
  localparam int W            = 32;

  typedef struct packed {
    int unsigned          due;
    logic [3:0]           rob;
    logic [5:0]           rd;
    logic [W-1:0]         result;
    logic [NUM_FLAGS-1:0] flags;
  } expect_t;

  logic                 clk;
  logic                 reset;
  logic                 issue_v;
  op_e                  opcode;
  logic [W-1:0]         operand1;
  logic [W-1:0]         operand2;
  logic [3:0]           rob_dest;
  logic [5:0]           reg_dest;
  logic                 issue_stall;
  logic                 wb_v;
  logic [3:0]           wb_rob_dest;
  logic [5:0]           wb_reg_dest;
  logic [W-1:0]         wb_result;
  logic [NUM_FLAGS-1:0] wb_flags;

  expect_t     exp_q[$];
  int unsigned cycle = 0;
  int          last_stalls;
  int          ops_issued = 0;

  exec_cluster UUT (
    .clk_i         (clk),
    .reset_i       (reset),
    .issue_v_i     (issue_v),
    .opcode_i      (opcode),
    .operand1_i    (operand1),
    .operand2_i    (operand2),
    .rob_dest_i    (rob_dest),
    .reg_dest_i    (reg_dest),
    .issue_stall_o (issue_stall),
    .wb_v_o        (wb_v),
    .wb_rob_dest_o (wb_rob_dest),
    .wb_reg_dest_o (wb_reg_dest),
    .wb_result_o   (wb_result),
    .wb_flags_o    (wb_flags)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  task automatic stop_failed();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("Fail %s expected %h actual %h", name, expected, actual);
      stop_failed();
    end
  endtask

  // result and flags for one operation, bit by bit from the ISA rules
  function automatic logic [NUM_FLAGS+W-1:0] model_op(input logic [3:0] op,
                                                     input logic [W-1:0] a,
                                                     input logic [W-1:0] b);
    logic [W-1:0]         r;
    logic [W:0]           wide;
    logic [2*W-1:0]       prod;
    logic [NUM_FLAGS-1:0] f;
    logic                 c;
    logic                 v;
    int                   k;
    int                   i;
    r = '0;
    c = 1'b0;
    v = 1'b0;
    // amounts past W shift everything out
    k = (b < W) ? int'(b) : W;
    case (op)
      OP_AND:  r = a & b;
      OP_XOR:  r = a ^ b;
      OP_OR:   r = a | b;
      OP_NEG:  r = ~b;
      OP_LSLS:
      begin
        for (i = k; i < W; i++)
          r[i] = a[i - k];
        c = (b != 0 && b <= W) ? a[W - k] : 1'b0;
      end
      OP_LSRS:
      begin
        for (i = 0; i < W - k; i++)
          r[i] = a[i + k];
        c = (b != 0 && b <= W) ? a[k - 1] : 1'b0;
      end
      OP_ASRS:
      begin
        r = {W{a[W-1]}};
        for (i = 0; i < W - k; i++)
          r[i] = a[i + k];
        c = (b == 0) ? 1'b0 : (b <= W) ? a[k - 1] : a[W-1];
      end
      OP_RORS:
      begin
        k = int'(b % W);
        for (i = 0; i < W; i++)
          r[i] = a[(i + k) % W];
        c = (b != 0) && r[W-1];
      end
      OP_ADDS:
      begin
        wide = {1'b0, a} + {1'b0, b};
        r    = wide[W-1:0];
        c    = wide[W];
        v    = (a[W-1] == b[W-1]) && (r[W-1] != a[W-1]);
      end
      OP_SUBS:
      begin
        r = a - b;
        c = (a >= b);
        v = (a[W-1] != b[W-1]) && (r[W-1] != a[W-1]);
      end
      OP_MULS:
      begin
        prod = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        r    = prod[W-1:0];
      end
      default: r = '0;
    endcase
    f         = '0;
    f[FLAG_C] = c;
    f[FLAG_N] = r[W-1];
    f[FLAG_Z] = (r == '0);
    f[FLAG_V] = v;
    return {f, r};
  endfunction

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic issue_op(input logic [3:0] op, input logic [W-1:0] a,
                          input logic [W-1:0] b);
    expect_t               e;
    logic [NUM_FLAGS+W-1:0] m;
    issue_v     = 1'b1;
    opcode      = op_e'(op);
    operand1    = a;
    operand2    = b;
    rob_dest    = 4'($urandom);
    reg_dest    = 6'($urandom);
    last_stalls = 0;
    #1;
    while (issue_stall)
    begin
      last_stalls++;
      @(negedge clk);
      #1;
    end
    m        = model_op(op, a, b);
    e.due    = cycle + ((op == OP_MULS) ? 3 : 2);
    e.rob    = rob_dest;
    e.rd     = reg_dest;
    e.result = m[W-1:0];
    e.flags  = m[NUM_FLAGS+W-1:W];
    exp_q.push_back(e);
    ops_issued++;
    @(negedge clk);
    issue_v = 1'b0;
  endtask

  task automatic drain_results();
    while (exp_q.size() != 0)
      @(negedge clk);
  endtask

  // compare each broadcast against the oldest outstanding expectation
  always @(negedge clk)
  begin : monitor
    expect_t e;
    if (!reset && wb_v)
    begin
      if (exp_q.size() == 0)
      begin
        $display("error: broadcast seen with no operation outstanding");
        stop_failed();
      end
      else
      begin
        e = exp_q.pop_front();
        check_value("wb_v_o arrival cycle", e.due, cycle);
        check_value("wb_rob_dest_o", e.rob, wb_rob_dest);
        check_value("wb_reg_dest_o", e.rd, wb_reg_dest);
        check_value("wb_result_o", e.result, wb_result);
        check_value("wb_flags_o", e.flags, wb_flags);
      end
    end
    else if (exp_q.size() != 0 && exp_q[0].due <= cycle)
    begin
      $display("error: expected broadcast for rob %0d did not arrive", exp_q[0].rob);
      stop_failed();
    end
  end

  task automatic reset_state();
    repeat (5)
    begin
      @(negedge clk);
      check_value("wb_v_o", 0, wb_v);
      check_value("issue_stall_o", 0, issue_stall);
    end
  endtask

  task automatic logic_ops();
    logic [W-1:0] la [3];
    logic [W-1:0] lb [3];
    int           op;
    int           i;
    la = '{32'hF0F0_F0F0, 32'hFFFF_FFFF, 32'h8000_0001};
    lb = '{32'h0F0F_0F0F, 32'hFFFF_FFFF, 32'h8000_0000};
    for (op = 0; op < 4; op++)
    begin
      for (i = 0; i < 3; i++)
        issue_op(4'(op), la[i], lb[i]);
      repeat (8)
        issue_op(4'(op), $urandom, $urandom);
    end
    // undefined codes
    for (op = 11; op < 16; op++)
      issue_op(4'(op), $urandom, $urandom);
  endtask

  task automatic shift_ops();
    logic [W-1:0] amts [5];
    int           op;
    int           i;
    amts = '{0, 1, 31, 32, 40};
    for (op = 4; op < 8; op++)
    begin
      for (i = 0; i < 5; i++)
      begin
        issue_op(4'(op), 32'h8000_0001, amts[i]);
        issue_op(4'(op), 32'h7FFF_FFFE, amts[i]);
      end
      repeat (6)
        issue_op(4'(op), $urandom, $urandom_range(0, 63));
    end
  endtask

  task automatic arith_ops();
    logic [W-1:0] xa [8];
    logic [W-1:0] xb [8];
    int           i;
    xa = '{32'h1, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000,
           32'h8000_0000, 32'h7FFF_FFFF, 32'h1, 32'h5};
    xb = '{32'h1, 32'h1, 32'h1, 32'h8000_0000,
           32'h1, 32'hFFFF_FFFF, 32'h2, 32'h3};
    for (i = 0; i < 8; i++)
    begin
      issue_op(OP_ADDS, xa[i], xb[i]);
      issue_op(OP_SUBS, xa[i], xb[i]);
    end
    repeat (10)
      issue_op(4'(8 + $urandom_range(0, 1)), $urandom, $urandom);
  endtask

  task automatic mul_pipeline();
    logic [W-1:0] ma [4];
    int           i;
    ma = '{32'h0000_0003, 32'hFFFF_FFFF, 32'h0001_0000, 32'h8000_0000};
    for (i = 0; i < 4; i++)
    begin
      issue_op(OP_MULS, ma[i], ma[3 - i] + i);
      check_value("issue_stall_o cycles after MULS", 0, last_stalls);
    end
    // logic op right behind a multiply waits one cycle
    repeat (2)
    begin
      issue_op(OP_MULS, $urandom, $urandom);
      issue_op(OP_AND, $urandom, $urandom);
      check_value("issue_stall_o cycles after MULS", 1, last_stalls);
    end
  endtask

  task automatic mixed_stream();
    logic [3:0]   op;
    logic [W-1:0] b;
    repeat (NUM_RANDOM)
    begin
      op = 4'($urandom_range(0, 15));
      b  = (op >= 4 && op <= 7) ? $urandom_range(0, 40) : $urandom;
      issue_op(op, $urandom, b);
      repeat ($urandom_range(0, 2))
        @(negedge clk);
    end
  endtask

  initial
  begin
    #((RESET_CYCLES + 5 * (NUM_DIRECTED + NUM_RANDOM)) * CLK_PERIOD);
    $display("error: watchdog expired after %0d issued operations", ops_issued);
    stop_failed();
  end

  initial
  begin
    void'($urandom(32'h90f));
    reset    = 1'b1;
    issue_v  = 1'b0;
    opcode   = OP_AND;
    operand1 = '0;
    operand2 = '0;
    rob_dest = '0;
    reg_dest = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_state();
    logic_ops();
    drain_results();
    shift_ops();
    drain_results();
    arith_ops();
    drain_results();
    mul_pipeline();
    drain_results();
    mixed_stream();
    drain_results();
    repeat (4) @(negedge clk);
    if (exp_q.size() == 0)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      $display("error: %0d broadcasts still outstanding", exp_q.size());
      stop_failed();
    end
  end

endmodule

//--- all.f
pj_pkg.sv
fu_result_if.sv
exec_dispatch.sv
fu_logic.sv
fu_arith.sv
fu_mul.sv
cdb_writeback.sv
exec_cluster.sv
tb_exec_cluster.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  - pj_pkg.sv
  - fu_result_if.sv
  - exec_dispatch.sv
  - fu_logic.sv
  - fu_arith.sv
  - fu_mul.sv
  - cdb_writeback.sv
  - exec_cluster.sv
  - target: test
    files:
      - tb_exec_cluster.sv
